// File: include/memmap_defines.svh
// map geometry and field widths, included by the package and every memory map module
`ifndef MEMMAP_DEFINES_SVH
`define MEMMAP_DEFINES_SVH

// installed memory, bits of each frame number half that may be set
`define MEMMAP_MODULE_BITS 4    // module field, up to 16 modules
`define MEMMAP_FRAME_BITS 3     // frame field, 32K modules give 8 frames

// frame number halves
`define MEMMAP_FIELD_W 4

// logical side
`define MEMMAP_SEG_W 4          // segment number nb
`define MEMMAP_LADDR_W 16       // logical address
`define MEMMAP_OFFSET_W 12      // offset within a page

// page index = segment + top address bits
`define MEMMAP_PAGE_W 8
`define MEMMAP_MAP_DEPTH 256

// physical address = frame number + offset
`define MEMMAP_PADDR_W 20

// pages 0 and 1 map to frames 0 and 1, never configured
`define MEMMAP_FIXED_PAGES 2

`endif

// File: hdl/memmap_pkg.sv
// shared types of the memory map, imported by the FSM, the map logic and the testbench
`include "memmap_defines.svh"

package memmap_pkg;

	// configuration FSM states, 3-bit encoding printed by the testbench
	typedef enum logic [2:0] {
		S_IDLE  = 3'd0, // waiting for a command or a clear
		S_WRITE = 3'd1, // one map write
		S_ACK   = 3'd2, // ack held until cfg_req drops
		S_RESET = 3'd3, // held in reset
		S_CLEAR = 3'd4  // zeroing pages 2..255
	} cfg_state_e;

	// lookup request, rd strobe on top
	typedef struct packed {
		logic                       rd;
		logic [`MEMMAP_SEG_W-1:0]   nb;   // segment
		logic [`MEMMAP_LADDR_W-1:0] addr; // logical address
	} lookup_req_t;

	// lookup response, one cycle after the request
	typedef struct packed {
		logic [`MEMMAP_PADDR_W-1:0] phys_addr;
		logic                       pvalid; // page mapped
		logic                       valid;  // registered rd
	} lookup_rsp_t;

	// configuration command contents
	typedef struct packed {
		logic [`MEMMAP_PAGE_W-1:0] page;
		logic [`MEMMAP_PAGE_W-1:0] frame; // module in upper half, frame in lower
	} map_cfg_t;

	// map memory write port
	typedef struct packed {
		logic                      en;
		logic [`MEMMAP_PAGE_W-1:0] page;
		logic [`MEMMAP_PAGE_W-1:0] frame;
	} map_wr_t;

endpackage

// File: hdl/map_cfg_fsm.sv
// configuration FSM, validates map commands, drives map writes, ack and the map clear
`timescale 1ns/100ps
`include "memmap_defines.svh"

module map_cfg_fsm (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      cfg_req,  // command present
	input  logic                      cfg_en,   // command is a map config
	input  memmap_pkg::map_cfg_t      cfg,
	input  logic                      clear,    // clear request
	input  logic                      clr_last, // counter at last page
	input  logic [`MEMMAP_PAGE_W-1:0] clr_page,
	output logic                      cfg_ack,
	output logic                      busy,
	output logic                      clr_run,
	output memmap_pkg::map_wr_t       map_wr
);
	import memmap_pkg::*;

	// enabled bits of each frame number half
	localparam int mod_mask = (1 << `MEMMAP_MODULE_BITS) - 1;
	localparam int frm_mask = (1 << `MEMMAP_FRAME_BITS) - 1;
	localparam logic [`MEMMAP_PAGE_W-1:0] frame_mask = {
		mod_mask[`MEMMAP_FIELD_W-1:0],
		frm_mask[`MEMMAP_FIELD_W-1:0]
	};

	cfg_state_e state;
	cfg_state_e state_nxt;
	map_cfg_t   cmd;    // command captured in idle
	logic       cmd_ok;

	// accepted only for a configurable page and a frame within installed memory
	assign cmd_ok = cfg_req && cfg_en &&
		(cfg.page >= `MEMMAP_FIXED_PAGES) &&
		((cfg.frame & ~frame_mask) == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (clear) begin
					state_nxt = S_CLEAR; // clear wins over a command
				end else if (cmd_ok) begin
					state_nxt = S_WRITE;
				end
			end
			S_WRITE: state_nxt = S_ACK;
			S_ACK: begin
				if (!cfg_req) begin
					state_nxt = S_IDLE; // cpu released the command
				end
			end
			S_RESET: state_nxt = S_CLEAR; // reset released
			S_CLEAR: begin
				if (clr_last) begin
					state_nxt = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_RESET;
		end else begin
			state <= state_nxt;
		end
	end

	// command held for the write cycle
	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			cmd <= cfg;
		end
	end

	// write port, zeroes during clear
	assign map_wr.en    = (state == S_WRITE) || (state == S_CLEAR);
	assign map_wr.page  = (state == S_CLEAR) ? clr_page : cmd.page;
	assign map_wr.frame = (state == S_CLEAR) ? '0 : cmd.frame;

	assign cfg_ack = (state == S_ACK);
	assign busy    = (state == S_RESET) || (state == S_CLEAR);
	assign clr_run = (state == S_CLEAR);

	// a clear never starts straight out of an ack
	a_ack_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_ack |=> !busy);

	// the captured command never reaches a fixed page
	a_wr_not_fixed: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_WRITE) |-> (map_wr.page >= `MEMMAP_FIXED_PAGES));

endmodule

// File: hdl/map_clear_counter.sv
// page counter for the map clear, walks pages 2 to 255 and flags the last one
`timescale 1ns/100ps
`include "memmap_defines.svh"

module map_clear_counter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      clr_run,  // clear in progress
	output logic [`MEMMAP_PAGE_W-1:0] clr_page, // page being zeroed
	output logic                      clr_last
);

	// first configurable page when idle, reloaded after the last one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clr_page <= `MEMMAP_FIXED_PAGES;
		end else if (!clr_run || clr_last) begin
			clr_page <= `MEMMAP_FIXED_PAGES;
		end else begin
			clr_page <= clr_page + 1'b1;
		end
	end

	assign clr_last = (clr_page == '1); // page 255

	// the FSM stops the clear on the last page, so no wrap to page 0
	a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		(clr_run && clr_last) |=> !clr_run);

endmodule

// File: hdl/frame_map_ram.sv
// 256 entry page to frame map memory, one shared port with a registered read address
`timescale 1ns/100ps
`include "memmap_defines.svh"

module frame_map_ram (
	input  logic                      clk,
	input  memmap_pkg::map_wr_t       map_wr,
	input  logic [`MEMMAP_PAGE_W-1:0] lookup_page, // from the address former
	output logic [`MEMMAP_PAGE_W-1:0] frame
);

	logic [`MEMMAP_PAGE_W-1:0] mem [0:`MEMMAP_MAP_DEPTH-1];
	logic [`MEMMAP_PAGE_W-1:0] addr;    // shared port address
	logic [`MEMMAP_PAGE_W-1:0] rd_addr; // registered for the read

	// write page has priority over a lookup
	always_comb begin
		if (map_wr.en) begin
			addr = map_wr.page;
		end else begin
			addr = lookup_page;
		end
	end

	// contents defined by the clear after reset
	always_ff @(posedge clk) begin
		if (map_wr.en) begin
			mem[addr] <= map_wr.frame;
		end
		rd_addr <= addr;
	end

	// frame follows the lookup by one cycle
	assign frame = mem[rd_addr];

endmodule

// File: hdl/phys_addr_former.sv
// lookup stage, forms the page index and builds the physical address from the map frame
`timescale 1ns/100ps
`include "memmap_defines.svh"

module phys_addr_former (
	input  logic                      clk,
	input  logic                      rst_n,
	input  memmap_pkg::lookup_req_t   lookup_req,
	input  logic [`MEMMAP_PAGE_W-1:0] frame,       // map output, one cycle late
	output logic [`MEMMAP_PAGE_W-1:0] lookup_page, // to the map memory
	output memmap_pkg::lookup_rsp_t   lookup_rsp
);

	logic [`MEMMAP_OFFSET_W-1:0] offset_q;
	logic [`MEMMAP_PAGE_W-1:0]   fixed_frame_q; // page number doubles as frame
	logic                        fixed_q;       // page 0 or 1
	logic                        rd_q;
	logic [`MEMMAP_PAGE_W-1:0]   frame_eff;

	// segment + top address bits
	assign lookup_page = {lookup_req.nb, lookup_req.addr[`MEMMAP_LADDR_W-1:`MEMMAP_OFFSET_W]};

	// control flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fixed_q <= 1'b0;
			rd_q    <= 1'b0;
		end else begin
			fixed_q <= (lookup_page < `MEMMAP_FIXED_PAGES);
			rd_q    <= lookup_req.rd;
		end
	end

	// payload, every cycle
	always_ff @(posedge clk) begin
		offset_q      <= lookup_req.addr[`MEMMAP_OFFSET_W-1:0];
		fixed_frame_q <= lookup_page;
	end

	// hard-wired pages bypass the map
	assign frame_eff = fixed_q ? fixed_frame_q : frame;

	assign lookup_rsp.phys_addr = {frame_eff, offset_q};
	assign lookup_rsp.pvalid    = fixed_q || (frame != '0); // frame 0 means unmapped
	assign lookup_rsp.valid     = rd_q;

endmodule

// File: hdl/memmap_top.sv
// memory configuration map top, translates lookups and serves the map config commands
`timescale 1ns/100ps
`include "memmap_defines.svh"

module memmap_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    clear,      // map clear request
	input  logic                    cfg_req,    // command present
	input  logic                    cfg_en,     // qualifies cfg_req
	input  memmap_pkg::map_cfg_t    cfg,
	output logic                    cfg_ack,
	output logic                    busy,       // clear running
	input  memmap_pkg::lookup_req_t lookup_req,
	output memmap_pkg::lookup_rsp_t lookup_rsp
);
	import memmap_pkg::*;

	map_wr_t                   map_wr;      // fsm to map memory
	logic                      clr_run;
	logic [`MEMMAP_PAGE_W-1:0] clr_page;
	logic                      clr_last;
	logic [`MEMMAP_PAGE_W-1:0] frame;       // map read data
	logic [`MEMMAP_PAGE_W-1:0] lookup_page;

	// command validation, write control, clear sequencing
	map_cfg_fsm map_cfg_fsm_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_req  (cfg_req),
		.cfg_en   (cfg_en),
		.cfg      (cfg),
		.clear    (clear),
		.clr_last (clr_last),
		.clr_page (clr_page),
		.cfg_ack  (cfg_ack),
		.busy     (busy),
		.clr_run  (clr_run),
		.map_wr   (map_wr)
	);

	// pages 2..255 during clear
	map_clear_counter map_clear_counter_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.clr_run  (clr_run),
		.clr_page (clr_page),
		.clr_last (clr_last)
	);

	frame_map_ram frame_map_ram_inst (
		.clk         (clk),
		.map_wr      (map_wr),
		.lookup_page (lookup_page),
		.frame       (frame)
	);

	// page index out, physical address back
	phys_addr_former phys_addr_former_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_req  (lookup_req),
		.frame       (frame),
		.lookup_page (lookup_page),
		.lookup_rsp  (lookup_rsp)
	);

endmodule

// File: verification/memmap_tb.sv
// directed testbench for memmap_top, drives lookups and map commands and checks against a map model
`timescale 1ns/100ps
`include "memmap_defines.svh"

module memmap_tb;
	import memmap_pkg::*;

	localparam int clr_timeout = 400; // clear takes 254 cycles
	localparam int ack_timeout = 16;
	localparam int rej_cycles  = 8;   // window in which no ack may appear
	localparam int n_random    = 20;
	localparam int n_b2b       = 48;

	// enabled bits of each frame number half
	localparam logic [7:0] frame_mask = 8'(
		(((1 << `MEMMAP_MODULE_BITS) - 1) << `MEMMAP_FIELD_W) |
		((1 << `MEMMAP_FRAME_BITS) - 1));

	logic        clk;
	logic        rst_n;
	logic        clear;
	logic        cfg_req;
	logic        cfg_en;
	map_cfg_t    cfg;
	logic        cfg_ack;
	logic        busy;
	lookup_req_t lookup_req;
	lookup_rsp_t lookup_rsp;

	logic [7:0] ref_map [0:`MEMMAP_MAP_DEPTH-1]; // model, accepted commands only
	logic [7:0] cfg_pages [$];                   // pages written so far
	int         n_checks;
	int         n_errors;

	memmap_top memmap_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear      (clear),
		.cfg_req    (cfg_req),
		.cfg_en     (cfg_en),
		.cfg        (cfg),
		.cfg_ack    (cfg_ack),
		.busy       (busy),
		.lookup_req (lookup_req),
		.lookup_rsp (lookup_rsp)
	);

	always #5 clk = ~clk; // 10 ns period

	// fixed pages map to their own number
	function automatic logic [7:0] exp_frame(input logic [7:0] page);
		if (page < `MEMMAP_FIXED_PAGES) begin
			return page;
		end
		return ref_map[page];
	endfunction

	// acceptance rule for a config command
	function automatic logic cmd_accepted(input logic en, input logic [7:0] page,
		input logic [7:0] frame);
		return en && (page >= `MEMMAP_FIXED_PAGES) && ((frame & ~frame_mask) == 8'h00);
	endfunction

	task automatic check_eq(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		n_checks++;
		assert (exp === act) else begin
			$display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
			n_errors++;
		end
	endtask

	task automatic drive_lookup(input logic [7:0] page, input logic [11:0] off, input logic rd);
		lookup_req.rd   = rd;
		lookup_req.nb   = page[7:4];
		lookup_req.addr = {page[3:0], off}; // top nibble completes the page index
	endtask

	// response of a request sampled on the previous rising edge
	task automatic check_rsp(input string name, input logic [7:0] page, input logic [11:0] off,
		input logic rd);
		logic exp_pv;
		exp_pv = (page < `MEMMAP_FIXED_PAGES) || (exp_frame(page) != 8'h00);
		check_eq(name, "valid", 32'(rd), 32'(lookup_rsp.valid));
		check_eq(name, "phys_addr", 32'({exp_frame(page), off}), 32'(lookup_rsp.phys_addr));
		check_eq(name, "pvalid", 32'(exp_pv), 32'(lookup_rsp.pvalid));
	endtask

	task automatic lookup_once(input string name, input logic [7:0] page, input logic [11:0] off);
		drive_lookup(page, off, 1'b1);
		@(negedge clk);
		check_rsp(name, page, off, 1'b1);
		lookup_req.rd = 1'b0;
	endtask

	task automatic wait_busy(input string name, input logic level);
		int         n;
		cfg_state_e st;
		n = 0;
		while (busy !== level && n < clr_timeout) begin
			@(negedge clk);
			n++;
		end
		n_checks++;
		assert (busy === level) else begin
			st = memmap_top_inst.map_cfg_fsm_inst.state;
			$display("%s: busy did not go to %0d within %0d cycles, fsm state %s",
				name, level, clr_timeout, st.name());
			n_errors++;
		end
	endtask

	// one command, ack expected only when the rule accepts it
	task automatic config_cmd(input string name, input logic en, input logic [7:0] page,
		input logic [7:0] frame);
		int   n;
		logic acc;
		acc       = cmd_accepted(en, page, frame);
		cfg_req   = 1'b1;
		cfg_en    = en;
		cfg.page  = page;
		cfg.frame = frame;
		n = 0;
		if (acc) begin
			while (!cfg_ack && n < ack_timeout) begin
				@(negedge clk);
				n++;
			end
			n_checks++;
			assert (cfg_ack === 1'b1) else begin
				$display("%s: no cfg_ack for page %h within %0d cycles", name, page, ack_timeout);
				n_errors++;
			end
			ref_map[page] = frame;
		end else begin
			repeat (rej_cycles) begin
				@(negedge clk);
				check_eq(name, "cfg_ack", 32'h0, 32'(cfg_ack)); // rejected, no ack
			end
		end
		cfg_req = 1'b0;
		cfg_en  = 1'b0;
		n = 0;
		while (cfg_ack && n < ack_timeout) begin
			@(negedge clk);
			n++;
		end
		n_checks++;
		assert (cfg_ack === 1'b0) else begin
			$display("%s: cfg_ack still high %0d cycles after cfg_req fell", name, ack_timeout);
			n_errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: %0d errors", name, n_errors - errs_before);
	endtask

	task automatic test_clear_after_reset();
		int errs;
		int p;
		errs = n_errors;
		wait_busy("clear_after_reset", 1'b0);
		for (p = 0; p < `MEMMAP_MAP_DEPTH; p++) begin
			lookup_once("clear_after_reset", 8'(p), 12'($urandom)); // all but 0 and 1 unmapped
		end
		report_test("clear_after_reset", errs);
	endtask

	task automatic test_config_lookup();
		int         errs;
		logic [7:0] page;
		logic [7:0] frame;
		errs = n_errors;
		repeat (n_random) begin
			page  = 8'(`MEMMAP_FIXED_PAGES + ($urandom % (`MEMMAP_MAP_DEPTH - 2)));
			frame = 8'($urandom) & frame_mask;
			if (frame == 8'h00) begin
				frame = 8'h01; // zero reads as unmapped
			end
			config_cmd("config_lookup", 1'b1, page, frame);
			cfg_pages.push_back(page);
			lookup_once("config_lookup", page, 12'($urandom));
		end
		report_test("config_lookup", errs);
	endtask

	task automatic test_reject();
		int         errs;
		logic [7:0] target;
		logic [7:0] alt;
		logic [7:0] bad;
		errs   = n_errors;
		target = cfg_pages[0];
		alt    = ref_map[target] ^ 8'h11; // differs, still inside the mask
		bad    = ref_map[target] | (8'h01 << `MEMMAP_FRAME_BITS); // lowest disabled frame bit
		config_cmd("reject", 1'b0, target, alt);
		lookup_once("reject", target, 12'($urandom));
		config_cmd("reject", 1'b1, 8'h00, 8'h21);
		config_cmd("reject", 1'b1, 8'h01, 8'h21);
		lookup_once("reject", 8'h00, 12'($urandom));
		lookup_once("reject", 8'h01, 12'($urandom));
		config_cmd("reject", 1'b1, target, bad);
		lookup_once("reject", target, 12'($urandom));
		report_test("reject", errs);
	endtask

	// new request every cycle, previous response checked first
	task automatic test_b2b_lookup();
		int          errs;
		int          i;
		logic [7:0]  page;
		logic [11:0] off;
		logic        rd;
		logic [7:0]  prev_page;
		logic [11:0] prev_off;
		logic        prev_rd;
		errs = n_errors;
		prev_page = 8'h00;
		prev_off  = 12'h000;
		prev_rd   = 1'b0;
		for (i = 0; i < n_b2b; i++) begin
			if (i > 0) begin
				check_rsp("b2b_lookup", prev_page, prev_off, prev_rd);
			end
			if ($urandom % 2 == 0) begin
				page = cfg_pages[$urandom % cfg_pages.size()]; // mapped
			end else begin
				page = 8'($urandom); // mostly unmapped
			end
			off = 12'($urandom);
			rd  = ($urandom % 4) != 0; // some idle cycles
			drive_lookup(page, off, rd);
			prev_page = page;
			prev_off  = off;
			prev_rd   = rd;
			@(negedge clk);
		end
		check_rsp("b2b_lookup", prev_page, prev_off, prev_rd);
		lookup_req = '0;
		report_test("b2b_lookup", errs);
	endtask

	task automatic test_clear_request();
		int         errs;
		int         p;
		logic [7:0] page;
		errs = n_errors;
		repeat (4) begin
			page = 8'(`MEMMAP_FIXED_PAGES + ($urandom % (`MEMMAP_MAP_DEPTH - 2)));
			config_cmd("clear_request", 1'b1, page, (8'($urandom) & frame_mask) | 8'h01);
			cfg_pages.push_back(page);
		end
		clear = 1'b1; // one cycle pulse
		@(negedge clk);
		clear = 1'b0;
		wait_busy("clear_request", 1'b1);
		wait_busy("clear_request", 1'b0);
		for (p = `MEMMAP_FIXED_PAGES; p < `MEMMAP_MAP_DEPTH; p++) begin
			ref_map[p] = 8'h00;
		end
		foreach (cfg_pages[i]) begin
			lookup_once("clear_request", cfg_pages[i], 12'($urandom));
		end
		report_test("clear_request", errs);
	endtask

	initial begin
		void'($urandom(32'h5cac));
		n_checks   = 0;
		n_errors   = 0;
		clk        = 1'b0;
		rst_n      = 1'b0;
		clear      = 1'b0;
		cfg_req    = 1'b0;
		cfg_en     = 1'b0;
		cfg        = '0;
		lookup_req = '0;
		for (int i = 0; i < `MEMMAP_MAP_DEPTH; i++) begin
			ref_map[i] = 8'h00; // state after the reset clear
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		test_clear_after_reset();
		test_config_lookup();
		test_reject();
		test_b2b_lookup();
		test_clear_request();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: memmap_top.f
+incdir+include
hdl/memmap_pkg.sv
hdl/map_cfg_fsm.sv
hdl/map_clear_counter.sv
hdl/frame_map_ram.sv
hdl/phys_addr_former.sv
hdl/memmap_top.sv
verification/memmap_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory map testbench with Verilator, runs it and checks the log
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f memmap_top.f \
	--top-module memmap_tb

./obj_dir/Vmemmap_tb 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0
